//--- rtl/axis_pkg.sv
/*
 * stream beat definitions
 * byte-wide data plus last and user sideband
 */
`default_nettype none

package axis_pkg;

    // bits per stream byte
    localparam int DATA_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // one stored stream beat, kept as a single word in FIFOs and register slices
    typedef struct packed {
        data_t data;
        logic  last;
        logic  user;
    } beat_t;

endpackage

`default_nettype wire

//--- rtl/join_pkg.sv
/*
 * frame joiner constants
 * port count, tag size, input FIFO depth and joiner state encoding
 */
`default_nettype none

package join_pkg;

    localparam int PORT_COUNT = 4;

    typedef logic [1:0] port_t;

    // tag goes out most significant byte first
    localparam int TAG_WIDTH = 16;
    localparam int TAG_BYTES = (TAG_WIDTH + 7) / 8;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // entries per input FIFO, power of two
    localparam int FIFO_DEPTH = 4;

    typedef enum logic [1:0] {
        idle,
        write_tag,
        transfer
    } state_t;

endpackage

`default_nettype wire

//--- rtl/axis_fifo.sv
/*
 * stream FIFO for one input port
 * stores data, last and user of each beat in a circular buffer
 */
`default_nettype none

module axis_fifo #(
    parameter int DEPTH = join_pkg::FIFO_DEPTH
) (
    input  wire             clk,
    input  wire             rst,

    input  axis_pkg::data_t in_tdata,
    input  wire             in_tvalid,
    output logic            in_tready,
    input  wire             in_tlast,
    input  wire             in_tuser,

    output axis_pkg::data_t out_tdata,
    output logic            out_tvalid,
    input  wire             out_tready,
    output logic            out_tlast,
    output logic            out_tuser
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    axis_pkg::beat_t mem [DEPTH];

    // one extra pointer bit tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic            full;
    logic            empty;
    logic            wr_en;
    logic            rd_en;
    axis_pkg::beat_t wr_beat;
    axis_pkg::beat_t rd_beat;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    // a full FIFO still takes a beat when the head leaves in the same cycle
    assign in_tready = !full || out_tready;
    assign out_tvalid = !empty;

    assign wr_en = in_tvalid && in_tready;
    assign rd_en = out_tvalid && out_tready;

    assign wr_beat = '{data: in_tdata, last: in_tlast, user: in_tuser};
    assign rd_beat = mem[rd_ptr[ADDR_WIDTH-1:0]];

    assign out_tdata = rd_beat.data;
    assign out_tlast = rd_beat.last;
    assign out_tuser = rd_beat.user;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/axis_skid_buffer.sv
/*
 * two-entry stream register slice
 * output register plus a temporary register, upstream ready comes from a flop
 */
`default_nettype none

module axis_skid_buffer (
    input  wire             clk,
    input  wire             rst,

    input  axis_pkg::data_t in_tdata,
    input  wire             in_tvalid,
    output logic            in_tready,
    input  wire             in_tlast,
    input  wire             in_tuser,

    output axis_pkg::data_t out_tdata,
    output logic            out_tvalid,
    input  wire             out_tready,
    output logic            out_tlast,
    output logic            out_tuser
);

    axis_pkg::beat_t in_beat;
    axis_pkg::beat_t out_beat;
    axis_pkg::beat_t temp_beat;

    logic out_valid;
    logic temp_valid;
    logic accept;
    logic out_free;

    assign in_beat = '{data: in_tdata, last: in_tlast, user: in_tuser};

    // ready is the inverse of a flop, so it never depends on out_tready
    assign in_tready = !temp_valid;
    assign accept = in_tvalid && in_tready;

    // output register is empty or is handing its beat over this cycle
    assign out_free = out_tready || !out_valid;

    assign out_tvalid = out_valid;
    assign out_tdata = out_beat.data;
    // no stale last once the output register has drained
    assign out_tlast = out_valid && out_beat.last;
    assign out_tuser = out_beat.user;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else if (out_free) begin
            // temp drains first, no new beat can arrive while it is full
            out_valid <= temp_valid || accept;
            temp_valid <= 1'b0;
        end else if (accept) begin
            temp_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (temp_valid) begin
                out_beat <= temp_beat;
            end else if (accept) begin
                out_beat <= in_beat;
            end
        end else if (accept) begin
            temp_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

//--- rtl/axis_frame_join.sv
/*
 * four-port frame joiner
 * sends the tag, then the frames of ports 0 to 3 back to back, with merged tuser
 */
`default_nettype none

module axis_frame_join (
    input  wire                                            clk,
    input  wire                                            rst,

    input  axis_pkg::data_t [join_pkg::PORT_COUNT-1:0]     fifo_tdata,
    input  wire             [join_pkg::PORT_COUNT-1:0]     fifo_tvalid,
    output logic            [join_pkg::PORT_COUNT-1:0]     fifo_tready,
    input  wire             [join_pkg::PORT_COUNT-1:0]     fifo_tlast,
    input  wire             [join_pkg::PORT_COUNT-1:0]     fifo_tuser,

    input  join_pkg::tag_t                                 tag,

    output axis_pkg::data_t                                join_tdata,
    output logic                                           join_tvalid,
    input  wire                                            join_tready,
    output logic                                           join_tlast,
    output logic                                           join_tuser,

    output logic                                           busy
);

    typedef logic [$clog2(join_pkg::TAG_BYTES)-1:0] tag_idx_t;

    join_pkg::state_t state;
    join_pkg::state_t state_next;

    // counts down from the most significant tag byte
    tag_idx_t tag_idx;
    tag_idx_t tag_idx_next;

    join_pkg::port_t port_sel;
    join_pkg::port_t port_sel_next;

    logic user_flag;
    logic user_flag_next;

    axis_pkg::data_t [join_pkg::TAG_BYTES-1:0] tag_bytes;

    logic sel_take;
    logic sel_last_port;

    assign tag_bytes = tag;

    assign sel_take = fifo_tvalid[port_sel] && join_tready;
    assign sel_last_port = (port_sel == join_pkg::port_t'(join_pkg::PORT_COUNT - 1));

    always_comb begin
        state_next = state;
        tag_idx_next = tag_idx;
        port_sel_next = port_sel;
        user_flag_next = user_flag;

        fifo_tready = '0;
        join_tdata = '0;
        join_tvalid = 1'b0;
        join_tlast = 1'b0;
        join_tuser = 1'b0;

        case (state)
            join_pkg::idle: begin
                tag_idx_next = tag_idx_t'(join_pkg::TAG_BYTES - 1);
                port_sel_next = '0;
                user_flag_next = 1'b0;
                // start once port 0 has something to send
                if (fifo_tvalid[0]) begin
                    state_next = join_pkg::write_tag;
                end
            end
            join_pkg::write_tag: begin
                join_tdata = tag_bytes[tag_idx];
                join_tvalid = 1'b1;
                if (join_tready) begin
                    tag_idx_next = tag_idx - 1'b1;
                    if (tag_idx == '0) begin
                        state_next = join_pkg::transfer;
                    end
                end
            end
            join_pkg::transfer: begin
                fifo_tready[port_sel] = join_tready;
                join_tdata = fifo_tdata[port_sel];
                join_tvalid = fifo_tvalid[port_sel];

                // final beat of port 3 carries the merged tuser
                if (fifo_tlast[port_sel] && sel_last_port) begin
                    join_tlast = 1'b1;
                    join_tuser = user_flag || fifo_tuser[port_sel];
                end

                if (sel_take && fifo_tlast[port_sel]) begin
                    user_flag_next = user_flag || fifo_tuser[port_sel];
                    port_sel_next = port_sel + 1'b1;
                    if (sel_last_port) begin
                        // end of the joined frame
                        state_next = join_pkg::idle;
                    end
                end
            end
            default: begin
                state_next = join_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= join_pkg::idle;
            tag_idx <= '0;
            port_sel <= '0;
            user_flag <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            tag_idx <= tag_idx_next;
            port_sel <= port_sel_next;
            user_flag <= user_flag_next;
            busy <= (state_next != join_pkg::idle);
        end
    end

endmodule

`default_nettype wire

//--- rtl/frame_join_top.sv
/*
 * frame join top level
 * four input FIFOs feed the joiner, a skid buffer decouples the output
 */
`default_nettype none

module frame_join_top (
    input  wire                                            clk,
    input  wire                                            rst,

    input  axis_pkg::data_t [join_pkg::PORT_COUNT-1:0]     in_tdata,
    input  wire             [join_pkg::PORT_COUNT-1:0]     in_tvalid,
    output logic            [join_pkg::PORT_COUNT-1:0]     in_tready,
    input  wire             [join_pkg::PORT_COUNT-1:0]     in_tlast,
    input  wire             [join_pkg::PORT_COUNT-1:0]     in_tuser,

    output axis_pkg::data_t                                out_tdata,
    output logic                                           out_tvalid,
    input  wire                                            out_tready,
    output logic                                           out_tlast,
    output logic                                           out_tuser,

    input  join_pkg::tag_t                                 tag,
    output logic                                           busy
);

    axis_pkg::data_t [join_pkg::PORT_COUNT-1:0] fifo_tdata;
    logic            [join_pkg::PORT_COUNT-1:0] fifo_tvalid;
    logic            [join_pkg::PORT_COUNT-1:0] fifo_tready;
    logic            [join_pkg::PORT_COUNT-1:0] fifo_tlast;
    logic            [join_pkg::PORT_COUNT-1:0] fifo_tuser;

    axis_pkg::data_t join_tdata;
    logic            join_tvalid;
    logic            join_tready;
    logic            join_tlast;
    logic            join_tuser;

    // one FIFO per input port
    for (genvar k = 0; k < join_pkg::PORT_COUNT; k++) begin : g_port
        axis_fifo #(
            .DEPTH(join_pkg::FIFO_DEPTH)
        ) axis_fifo_i (
            .clk(clk),
            .rst(rst),
            .in_tdata(in_tdata[k]),
            .in_tvalid(in_tvalid[k]),
            .in_tready(in_tready[k]),
            .in_tlast(in_tlast[k]),
            .in_tuser(in_tuser[k]),
            .out_tdata(fifo_tdata[k]),
            .out_tvalid(fifo_tvalid[k]),
            .out_tready(fifo_tready[k]),
            .out_tlast(fifo_tlast[k]),
            .out_tuser(fifo_tuser[k])
        );
    end

    axis_frame_join axis_frame_join_i (
        .clk(clk),
        .rst(rst),
        .fifo_tdata(fifo_tdata),
        .fifo_tvalid(fifo_tvalid),
        .fifo_tready(fifo_tready),
        .fifo_tlast(fifo_tlast),
        .fifo_tuser(fifo_tuser),
        .tag(tag),
        .join_tdata(join_tdata),
        .join_tvalid(join_tvalid),
        .join_tready(join_tready),
        .join_tlast(join_tlast),
        .join_tuser(join_tuser),
        .busy(busy)
    );

    axis_skid_buffer axis_skid_buffer_i (
        .clk(clk),
        .rst(rst),
        .in_tdata(join_tdata),
        .in_tvalid(join_tvalid),
        .in_tready(join_tready),
        .in_tlast(join_tlast),
        .in_tuser(join_tuser),
        .out_tdata(out_tdata),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tlast(out_tlast),
        .out_tuser(out_tuser)
    );

endmodule

`default_nettype wire

//--- bench/frame_join_chk.sv
/*
 * frame join protocol checker
 * concurrent assertions on the output stream and busy, bound to the top level
 */
`default_nettype none

module frame_join_chk (
    input wire             clk,
    input wire             rst,
    input axis_pkg::data_t out_tdata,
    input wire             out_tvalid,
    input wire             out_tready,
    input wire             out_tlast,
    input wire             out_tuser,
    input wire             busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench after each case
    int fail_count = 0;

    // a stalled beat stays valid and unchanged
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=>
            out_tvalid && $stable(out_tdata) && $stable(out_tlast) && $stable(out_tuser))
    else begin
        fail_count++;
        $error("output beat changed while stalled");
    end

    reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !out_tvalid && !busy)
    else begin
        fail_count++;
        $error("output valid or busy set right after reset");
    end

    // tlast only carries meaning together with tvalid
    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        out_tlast |-> out_tvalid)
    else begin
        fail_count++;
        $error("output last set without output valid");
    end

endmodule

`default_nettype wire

//--- bench/tb_frame_join.sv
/*
 * frame join testbench
 * table-driven cases with random gaps and stalls, output checked against a queue
 */
`default_nettype none

module tb_frame_join;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CASE_COUNT = 6;
    localparam int MAX_LEN = 5;
    localparam int TIMEOUT = 2000;

    // lens and user are listed port 0 first
    typedef struct packed {
        join_pkg::tag_t  tag;
        logic [0:3][2:0] lens;
        logic [0:3]      user;
        logic [6:0]      gap_pct;
        logic [6:0]      stall_pct;
    } case_t;

    case_t cases [CASE_COUNT] = '{
        '{16'ha55a, '{3'd1, 3'd1, 3'd1, 3'd1}, 4'b0000, 7'd0, 7'd0},
        '{16'h1234, '{3'd5, 3'd5, 3'd5, 3'd5}, 4'b0001, 7'd0, 7'd0},
        '{16'hbeef, '{3'd3, 3'd1, 3'd4, 3'd2}, 4'b1000, 7'd30, 7'd0},
        '{16'h0f0f, '{3'd2, 3'd5, 3'd1, 3'd3}, 4'b0110, 7'd0, 7'd50},
        '{16'hc001, '{3'd4, 3'd4, 3'd2, 3'd5}, 4'b0000, 7'd40, 7'd40},
        '{16'h8001, '{3'd5, 3'd1, 3'd5, 3'd1}, 4'b1111, 7'd60, 7'd70}
    };

    logic clk;
    logic rst;

    axis_pkg::data_t [join_pkg::PORT_COUNT-1:0] in_tdata;
    logic            [join_pkg::PORT_COUNT-1:0] in_tvalid;
    logic            [join_pkg::PORT_COUNT-1:0] in_tready;
    logic            [join_pkg::PORT_COUNT-1:0] in_tlast;
    logic            [join_pkg::PORT_COUNT-1:0] in_tuser;

    axis_pkg::data_t out_tdata;
    logic            out_tvalid;
    logic            out_tready;
    logic            out_tlast;
    logic            out_tuser;

    join_pkg::tag_t  tag;
    logic            busy;

    integer          seed;
    int              cur_case;
    axis_pkg::data_t frame_data [join_pkg::PORT_COUNT][MAX_LEN];
    axis_pkg::beat_t expected [$];

    frame_join_top frame_join_top_i (
        .clk(clk),
        .rst(rst),
        .in_tdata(in_tdata),
        .in_tvalid(in_tvalid),
        .in_tready(in_tready),
        .in_tlast(in_tlast),
        .in_tuser(in_tuser),
        .out_tdata(out_tdata),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tlast(out_tlast),
        .out_tuser(out_tuser),
        .tag(tag),
        .busy(busy)
    );

    bind frame_join_top frame_join_chk frame_join_chk_i (
        .clk(clk),
        .rst(rst),
        .out_tdata(out_tdata),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tlast(out_tlast),
        .out_tuser(out_tuser),
        .busy(busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input axis_pkg::data_t exp,
                              input axis_pkg::data_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Fail: %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Fail: %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_tag_bytes(input join_pkg::tag_t exp, input join_pkg::tag_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Fail: tag expected 0x%h actual 0x%h", exp, act));
        end
    endtask

    function automatic int rand_pct();
        return $unsigned($random(seed)) % 100;
    endfunction

    // one source, with up to three idle cycles before each byte
    task automatic drive_port(input int p);
        int len;
        int i;
        int gaps;
        int guard;
        len = cases[cur_case].lens[p];
        for (i = 0; i < len; i++) begin
            gaps = 0;
            while (gaps < 3 && rand_pct() < cases[cur_case].gap_pct) begin
                in_tvalid[p] <= 1'b0;
                @(posedge clk);
                gaps++;
            end
            in_tdata[p] <= frame_data[p][i];
            in_tvalid[p] <= 1'b1;
            in_tlast[p] <= (i == len - 1);
            in_tuser[p] <= (i == len - 1) && cases[cur_case].user[p];
            guard = 0;
            do begin
                @(posedge clk);
                guard++;
                if (guard > TIMEOUT) begin
                    stop_with_failure($sformatf("input port %0d never became ready", p));
                end
            end while (!in_tready[p]);
        end
        in_tvalid[p] <= 1'b0;
        in_tlast[p] <= 1'b0;
        in_tuser[p] <= 1'b0;
    endtask

    // sink with random stalls, tag bytes first then the expected payload
    task automatic collect_output();
        join_pkg::tag_t  tag_seen;
        axis_pkg::beat_t exp_beat;
        int              beat_idx;
        int              guard;
        tag_seen = '0;
        beat_idx = 0;
        guard = 0;
        while (beat_idx < join_pkg::TAG_BYTES || expected.size() > 0) begin
            @(posedge clk);
            if (out_tvalid && out_tready) begin
                guard = 0;
                if (beat_idx == 0) begin
                    check_flag("busy", 1'b1, busy);
                end
                if (beat_idx < join_pkg::TAG_BYTES) begin
                    tag_seen = join_pkg::tag_t'({tag_seen, out_tdata});
                    check_flag("out_tlast", 1'b0, out_tlast);
                    check_flag("out_tuser", 1'b0, out_tuser);
                    if (beat_idx == join_pkg::TAG_BYTES - 1) begin
                        check_tag_bytes(cases[cur_case].tag, tag_seen);
                    end
                end else begin
                    exp_beat = expected.pop_front();
                    check_data("out_tdata", exp_beat.data, out_tdata);
                    check_flag("out_tlast", exp_beat.last, out_tlast);
                    check_flag("out_tuser", exp_beat.user, out_tuser);
                end
                beat_idx++;
            end else begin
                guard++;
                if (guard > TIMEOUT) begin
                    stop_with_failure($sformatf("no output beat arrived in case %0d", cur_case));
                end
            end
            out_tready <= (rand_pct() >= cases[cur_case].stall_pct);
        end
        out_tready <= 1'b1;
    endtask

    task automatic run_case(input int c);
        axis_pkg::beat_t beat;
        int              p;
        int              i;
        int              guard;
        cur_case = c;
        expected.delete();
        // tag bytes are checked apart, the queue holds the payload only
        for (p = 0; p < join_pkg::PORT_COUNT; p++) begin
            for (i = 0; i < cases[c].lens[p]; i++) begin
                frame_data[p][i] = axis_pkg::data_t'($random(seed));
                beat.data = frame_data[p][i];
                beat.last = (p == join_pkg::PORT_COUNT - 1) && (i == cases[c].lens[p] - 1);
                beat.user = beat.last && (|cases[c].user);
                expected.push_back(beat);
            end
        end
        tag <= cases[c].tag;
        fork
            drive_port(0);
            drive_port(1);
            drive_port(2);
            drive_port(3);
            collect_output();
        join
        // the output drains with no further beat after the final one
        guard = 0;
        while (out_tvalid) begin
            @(posedge clk);
            if (out_tvalid && out_tready) begin
                stop_with_failure($sformatf("extra output beat after case %0d", c));
            end
            guard++;
            if (guard > TIMEOUT) begin
                stop_with_failure($sformatf("output stayed valid after case %0d", c));
            end
        end
        check_flag("busy", 1'b0, busy);
        if (frame_join_top_i.frame_join_chk_i.fail_count != 0) begin
            stop_with_failure($sformatf("a protocol assertion failed in case %0d", c));
        end
    endtask

    initial begin
        seed = 32'haf7e672b;
        cur_case = 0;
        rst = 1'b1;
        in_tdata = '0;
        in_tvalid = '0;
        in_tlast = '0;
        in_tuser = '0;
        out_tready = 1'b0;
        tag = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        out_tready <= 1'b1;
        for (int c = 0; c < CASE_COUNT; c++) begin
            run_case(c);
        end
        if (frame_join_top_i.frame_join_chk_i.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- frame_join.f
rtl/axis_pkg.sv
rtl/join_pkg.sv
rtl/axis_fifo.sv
rtl/axis_skid_buffer.sv
rtl/axis_frame_join.sv
rtl/frame_join_top.sv
bench/frame_join_chk.sv
bench/tb_frame_join.sv

//--- Bender.yml
package:
  name: frame_join

sources:
  - files:
      - rtl/axis_pkg.sv
      - rtl/join_pkg.sv
      - rtl/axis_fifo.sv
      - rtl/axis_skid_buffer.sv
      - rtl/axis_frame_join.sv
      - rtl/frame_join_top.sv
  - target: simulation
    files:
      - bench/frame_join_chk.sv
      - bench/tb_frame_join.sv
